// ==== Bender.yml ====
package:
  name: data_feeder

sources:
  - include_dirs:
      - source
    files:
      - source/feeder_bus_pkg.sv
      - source/feeder_cmd_pkg.sv
      - source/feeder_regs.sv
      - source/read_request_gen.sv
      - source/line_unpacker.sv
      - source/sram_cmd_issuer.sv
      - source/data_feeder_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_data_feeder.sv

// ==== source/data_feeder_top.sv ====
`include "feeder_defines.svh"

module data_feeder_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       bus_strobe_i,
    input  feeder_bus_pkg::dram_addr_t bus_addr_i,
    input  logic                       bus_rw_i,
    input  feeder_bus_pkg::bus_word_t  bus_wdata_i,
    output logic                       bus_ready_o,
    output feeder_bus_pkg::bus_word_t  bus_rdata_o,
    input  logic                       fifo_addr_full_i,
    output logic                       dram_addr_valid_o,
    output feeder_bus_pkg::dram_addr_t dram_addr_o,
    input  logic                       fifo_data_empty_i,
    input  feeder_bus_pkg::line_half_t dram_rdata_h_i,
    input  feeder_bus_pkg::line_half_t dram_rdata_l_i,
    output logic                       fifo_data_rd_en_o,
    output logic                       cmd_valid_o,
    output feeder_cmd_pkg::opcode_e    cmd_o,
    output feeder_cmd_pkg::elem_t      cmd_data_o,
    output feeder_cmd_pkg::sram_idx_t  cmd_index_o
);
    import feeder_bus_pkg::*;
    import feeder_cmd_pkg::*;

    logic       start;
    logic       peek_mode;
    logic       sram_base_load;
    logic       req_busy;
    logic       unpack_busy;
    logic       elem_valid;
    dram_addr_t read_addr;
    sram_idx_t  read_len;
    sram_idx_t  sram_base;
    sram_idx_t  input_length;
    sram_idx_t  input_height;
    sram_idx_t  padding;
    sram_idx_t  boundary_padding;
    data_type_e data_type;
    elem_t      elem_data;
    elem_t      peek_data;

    // ##################################################################
    // host registers
    // ##################################################################
    feeder_regs u_regs (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .bus_strobe_i       (bus_strobe_i),
        .bus_addr_i         (bus_addr_i),
        .bus_rw_i           (bus_rw_i),
        .bus_wdata_i        (bus_wdata_i),
        .busy_i             (req_busy || unpack_busy),
        .peek_data_i        (peek_data),
        .bus_ready_o        (bus_ready_o),
        .bus_rdata_o        (bus_rdata_o),
        .start_o            (start),
        .read_addr_o        (read_addr),
        .read_len_o         (read_len),
        .peek_mode_o        (peek_mode),
        .data_type_o        (data_type),
        .sram_base_o        (sram_base),
        .sram_base_load_o   (sram_base_load),
        .input_length_o     (input_length),
        .input_height_o     (input_height),
        .padding_o          (padding),
        .boundary_padding_o (boundary_padding)
    );

    // ##################################################################
    // dram side: requests out, lines back
    // ##################################################################
    read_request_gen u_req (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .start_i           (start),
        .read_addr_i       (read_addr),
        .read_len_i        (read_len),
        .fifo_addr_full_i  (fifo_addr_full_i),
        .dram_addr_valid_o (dram_addr_valid_o),
        .dram_addr_o       (dram_addr_o),
        .busy_o            (req_busy)
    );

    line_unpacker u_unpack (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .start_i           (start),
        .peek_mode_i       (peek_mode),
        .read_addr_i       (read_addr),
        .read_len_i        (read_len),
        .fifo_data_empty_i (fifo_data_empty_i),
        .dram_rdata_h_i    (dram_rdata_h_i),
        .dram_rdata_l_i    (dram_rdata_l_i),
        .fifo_data_rd_en_o (fifo_data_rd_en_o),
        .elem_valid_o      (elem_valid),
        .elem_data_o       (elem_data),
        .peek_data_o       (peek_data),
        .busy_o            (unpack_busy)
    );

    // ##################################################################
    // accelerator command stream
    // ##################################################################
    sram_cmd_issuer u_issue (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start),
        .elem_valid_i       (elem_valid),
        .elem_data_i        (elem_data),
        .data_type_i        (data_type),
        .sram_base_i        (sram_base),
        .sram_base_load_i   (sram_base_load),
        .input_length_i     (input_length),
        .input_height_i     (input_height),
        .padding_i          (padding),
        .boundary_padding_i (boundary_padding),
        .cmd_valid_o        (cmd_valid_o),
        .cmd_o              (cmd_o),
        .cmd_data_o         (cmd_data_o),
        .cmd_index_o        (cmd_index_o)
    );

endmodule

// ==== source/feeder_bus_pkg.sv ====
`include "feeder_defines.svh"

package feeder_bus_pkg;

    // one word on the host register bus
    typedef logic [`XLEN-1:0] bus_word_t;

    // byte address into dram
    typedef logic [31:0] dram_addr_t;

    // a dram line comes back as two halves
    typedef logic [`HALF_BITS-1:0] line_half_t;

endpackage

// ==== source/feeder_cmd_pkg.sv ====
`include "feeder_defines.svh"

package feeder_cmd_pkg;

    typedef logic [`DATA_WIDTH-1:0] elem_t;

    // sram index, also used for element counts
    typedef logic [`ADDR_BITS-1:0] sram_idx_t;

    typedef enum logic {
        DT_INPUT  = 1'b0,
        DT_WEIGHT = 1'b1
    } data_type_e;

    // accelerator write opcodes
    typedef enum logic [`CMD_WIDTH-1:0] {
        CMD_WRITE_INPUT  = 8'd9,
        CMD_WRITE_WEIGHT = 8'd10
    } opcode_e;

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_WAIT,
        REQ_SEND
    } req_state_e;

    typedef enum logic [2:0] {
        UNP_IDLE,
        UNP_WAIT,
        UNP_WRITE,
        UNP_NEXT,
        UNP_PEEK
    } unpack_state_e;

endpackage

// ==== source/feeder_defines.svh ====
`ifndef FEEDER_DEFINES_SVH
`define FEEDER_DEFINES_SVH

// datapath widths
`define XLEN                 32
`define DATA_WIDTH           16
`define ADDR_BITS            15
`define CMD_WIDTH            8

// dram line geometry
`define LINE_BITS            512
`define HALF_BITS            256
`define LINE_BYTES           64
`define ELEMS_PER_LINE       32

// host register map, word addresses
`define REG_START            32'hC400_2000
`define REG_READ_ADDR        32'hC400_2004
`define REG_READ_LEN         32'hC400_2008
`define REG_LOAD_MODE        32'hC400_200C
`define REG_DATA_TYPE        32'hC400_2010
`define REG_SRAM_OFFSET      32'hC400_2014
`define REG_INPUT_LENGTH     32'hC400_2018
`define REG_INPUT_HEIGHT     32'hC400_201C
`define REG_PADDING          32'hC400_2020
`define REG_BOUNDARY_PADDING 32'hC400_2024
`define REG_BUSY             32'hC400_2028
`define REG_PEEK_DATA        32'hC400_202C

`endif

// ==== source/feeder_regs.sv ====
`include "feeder_defines.svh"

module feeder_regs (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       bus_strobe_i,
    input  feeder_bus_pkg::dram_addr_t bus_addr_i,
    input  logic                       bus_rw_i,
    input  feeder_bus_pkg::bus_word_t  bus_wdata_i,
    input  logic                       busy_i,
    input  feeder_cmd_pkg::elem_t      peek_data_i,
    output logic                       bus_ready_o,
    output feeder_bus_pkg::bus_word_t  bus_rdata_o,
    output logic                       start_o,
    output feeder_bus_pkg::dram_addr_t read_addr_o,
    output feeder_cmd_pkg::sram_idx_t  read_len_o,
    output logic                       peek_mode_o,
    output feeder_cmd_pkg::data_type_e data_type_o,
    output feeder_cmd_pkg::sram_idx_t  sram_base_o,
    output logic                       sram_base_load_o,
    output feeder_cmd_pkg::sram_idx_t  input_length_o,
    output feeder_cmd_pkg::sram_idx_t  input_height_o,
    output feeder_cmd_pkg::sram_idx_t  padding_o,
    output feeder_cmd_pkg::sram_idx_t  boundary_padding_o
);
    import feeder_bus_pkg::*;
    import feeder_cmd_pkg::*;

    logic      wr_en;
    sram_idx_t wdata_idx;

    assign wr_en     = bus_strobe_i && bus_rw_i;
    assign wdata_idx = bus_wdata_i[`ADDR_BITS-1:0];

    // ready answers every strobe one cycle later
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bus_ready_o      <= 1'b0;
            start_o          <= 1'b0;
            sram_base_load_o <= 1'b0;
        end else begin
            bus_ready_o      <= bus_strobe_i;
            start_o          <= wr_en && (bus_addr_i == `REG_START);
            sram_base_load_o <= wr_en && (bus_addr_i == `REG_SRAM_OFFSET);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            read_addr_o        <= '0;
            read_len_o         <= '0;
            peek_mode_o        <= 1'b0;
            data_type_o        <= DT_INPUT;
            sram_base_o        <= '0;
            input_length_o     <= '0;
            input_height_o     <= '0;
            padding_o          <= '0;
            boundary_padding_o <= '0;
        end else if (wr_en) begin
            case (bus_addr_i)
                `REG_READ_ADDR:        read_addr_o        <= bus_wdata_i;
                `REG_READ_LEN:         read_len_o         <= wdata_idx;
                `REG_LOAD_MODE:        peek_mode_o        <= bus_wdata_i[0];
                `REG_DATA_TYPE:        data_type_o        <= data_type_e'(bus_wdata_i[0]);
                `REG_SRAM_OFFSET:      sram_base_o        <= wdata_idx;
                `REG_INPUT_LENGTH:     input_length_o     <= wdata_idx;
                `REG_INPUT_HEIGHT:     input_height_o     <= wdata_idx;
                `REG_PADDING:          padding_o          <= wdata_idx;
                `REG_BOUNDARY_PADDING: boundary_padding_o <= wdata_idx;
                default: ;
            endcase
        end
    end

    // read-back mux, zero for anything not readable
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bus_rdata_o <= '0;
        end else if (bus_strobe_i && !bus_rw_i) begin
            case (bus_addr_i)
                `REG_BUSY:      bus_rdata_o <= bus_word_t'(busy_i);
                `REG_PEEK_DATA: bus_rdata_o <= bus_word_t'(peek_data_i);
                default:        bus_rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== source/line_unpacker.sv ====
`include "feeder_defines.svh"

module line_unpacker (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  logic                       peek_mode_i,
    input  feeder_bus_pkg::dram_addr_t read_addr_i,
    input  feeder_cmd_pkg::sram_idx_t  read_len_i,
    input  logic                       fifo_data_empty_i,
    input  feeder_bus_pkg::line_half_t dram_rdata_h_i,
    input  feeder_bus_pkg::line_half_t dram_rdata_l_i,
    output logic                       fifo_data_rd_en_o,
    output logic                       elem_valid_o,
    output feeder_cmd_pkg::elem_t      elem_data_o,
    output feeder_cmd_pkg::elem_t      peek_data_o,
    output logic                       busy_o
);
    import feeder_bus_pkg::*;
    import feeder_cmd_pkg::*;

    unpack_state_e         state_q;
    unpack_state_e         state_d;
    line_half_t            line_h_q;
    line_half_t            line_l_q;
    logic [`LINE_BITS-1:0] line_w;
    elem_t                 elems [`ELEMS_PER_LINE];
    dram_addr_t            ptr_q;
    sram_idx_t             sent_q;
    logic [4:0]            elem_idx;
    logic                  line_done;
    logic                  xfer_done;

    assign line_w    = {line_h_q, line_l_q};
    assign elem_idx  = ptr_q[5:1];
    assign line_done = (elem_idx == 5'(`ELEMS_PER_LINE - 1));
    assign xfer_done = (sent_q + sram_idx_t'(1) == read_len_i);

    // word k from the top of a half holds element 2k low, 2k+1 high
    always_comb begin
        for (int k = 0; k < `ELEMS_PER_LINE / 4; k++) begin
            {elems[2*k+1], elems[2*k]}   = line_w[`HALF_BITS-1-32*k -: 32];
            {elems[2*k+17], elems[2*k+16]} = line_w[`LINE_BITS-1-32*k -: 32];
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            UNP_IDLE:
                if (start_i) state_d = UNP_WAIT;
            UNP_WAIT:
                if (!fifo_data_empty_i) state_d = peek_mode_i ? UNP_PEEK : UNP_WRITE;
            UNP_WRITE:
                if (line_done || xfer_done) state_d = UNP_NEXT;
            UNP_NEXT:
                state_d = (sent_q == read_len_i) ? UNP_IDLE : UNP_WAIT;
            default:
                state_d = UNP_IDLE;
        endcase
    end

    // head of the data fifo, held while it has a line
    always_ff @(posedge clk_i) begin
        if (!fifo_data_empty_i) begin
            line_h_q <= dram_rdata_h_i;
            line_l_q <= dram_rdata_l_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= UNP_IDLE;
            ptr_q       <= '0;
            sent_q      <= '0;
            peek_data_o <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == UNP_IDLE && start_i) begin
                ptr_q  <= read_addr_i;
                sent_q <= '0;
            end else if (state_q == UNP_WRITE) begin
                ptr_q  <= ptr_q + dram_addr_t'(2);
                sent_q <= sent_q + sram_idx_t'(1);
            end
            if (state_q == UNP_PEEK) begin
                peek_data_o <= elems[elem_idx];
            end
        end
    end

    // peek pops its line just like a finished feed line
    assign fifo_data_rd_en_o = (state_q == UNP_NEXT) || (state_q == UNP_PEEK);
    assign elem_valid_o      = (state_q == UNP_WRITE);
    assign elem_data_o       = elems[elem_idx];
    assign busy_o            = (state_q != UNP_IDLE);

endmodule

// ==== source/read_request_gen.sv ====
`include "feeder_defines.svh"

module read_request_gen (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  feeder_bus_pkg::dram_addr_t read_addr_i,
    input  feeder_cmd_pkg::sram_idx_t  read_len_i,
    input  logic                       fifo_addr_full_i,
    output logic                       dram_addr_valid_o,
    output feeder_bus_pkg::dram_addr_t dram_addr_o,
    output logic                       busy_o
);
    import feeder_bus_pkg::*;
    import feeder_cmd_pkg::*;

    req_state_e state_q;
    req_state_e state_d;
    dram_addr_t addr_q;
    sram_idx_t  req_cnt_q;
    logic [6:0] line_gap;
    sram_idx_t  span;
    logic       last_req;

    // bytes up to the next line boundary, two per element
    assign line_gap = 7'(`LINE_BYTES) - {1'b0, addr_q[5:0]};
    assign span     = sram_idx_t'(line_gap[6:1]);
    assign last_req = (req_cnt_q + span) >= read_len_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            REQ_IDLE:
                if (start_i) state_d = REQ_WAIT;
            REQ_WAIT:
                if (!fifo_addr_full_i) state_d = REQ_SEND;
            REQ_SEND:
                state_d = last_req ? REQ_IDLE : REQ_WAIT;
            default:
                state_d = REQ_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= REQ_IDLE;
            addr_q    <= '0;
            req_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == REQ_IDLE && start_i) begin
                addr_q    <= read_addr_i;
                req_cnt_q <= '0;
            end else if (state_q == REQ_SEND) begin
                addr_q    <= addr_q + dram_addr_t'(line_gap);
                req_cnt_q <= req_cnt_q + span;
            end
        end
    end

    assign dram_addr_valid_o = (state_q == REQ_SEND);
    assign dram_addr_o       = addr_q;
    assign busy_o            = (state_q != REQ_IDLE);

endmodule

// ==== source/sram_cmd_issuer.sv ====
`include "feeder_defines.svh"

module sram_cmd_issuer (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  logic                       elem_valid_i,
    input  feeder_cmd_pkg::elem_t      elem_data_i,
    input  feeder_cmd_pkg::data_type_e data_type_i,
    input  feeder_cmd_pkg::sram_idx_t  sram_base_i,
    input  logic                       sram_base_load_i,
    input  feeder_cmd_pkg::sram_idx_t  input_length_i,
    input  feeder_cmd_pkg::sram_idx_t  input_height_i,
    input  feeder_cmd_pkg::sram_idx_t  padding_i,
    input  feeder_cmd_pkg::sram_idx_t  boundary_padding_i,
    output logic                       cmd_valid_o,
    output feeder_cmd_pkg::opcode_e    cmd_o,
    output feeder_cmd_pkg::elem_t      cmd_data_o,
    output feeder_cmd_pkg::sram_idx_t  cmd_index_o
);
    import feeder_cmd_pkg::*;

    sram_idx_t offset_q;
    sram_idx_t col_q;
    sram_idx_t row_q;
    logic      is_input;
    logic      col_end;
    logic      row_end;
    logic      last_row;

    assign is_input = (data_type_i == DT_INPUT);
    assign col_end  = (col_q + sram_idx_t'(1) == input_length_i);
    assign row_end  = is_input && col_end;
    assign last_row = row_end && (row_q + sram_idx_t'(1) == input_height_i);

    // position inside the input tile
    always_ff @(posedge clk_i) begin
        if (rst_i || start_i) begin
            col_q <= '0;
            row_q <= '0;
        end else if (elem_valid_i) begin
            col_q <= col_end ? '0 : col_q + sram_idx_t'(1);
            row_q <= col_end ? row_q + sram_idx_t'(1) : row_q;
        end
    end

    // skip the padding columns at each row end, the bottom border after the last row
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            offset_q <= '0;
        end else if (sram_base_load_i) begin
            offset_q <= sram_base_i;
        end else if (elem_valid_i) begin
            if (last_row) begin
                offset_q <= offset_q + boundary_padding_i + `ADDR_BITS'(1);
            end else if (row_end) begin
                offset_q <= offset_q + {padding_i[`ADDR_BITS-2:0], 1'b1};
            end else begin
                offset_q <= offset_q + `ADDR_BITS'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= elem_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (elem_valid_i) begin
            if (is_input) begin
                cmd_o <= CMD_WRITE_INPUT;
            end else begin
                cmd_o <= CMD_WRITE_WEIGHT;
            end
            cmd_data_o  <= elem_data_i;
            cmd_index_o <= offset_q;
        end
    end

endmodule

// ==== sources.f ====
+incdir+source
source/feeder_bus_pkg.sv
source/feeder_cmd_pkg.sv
source/feeder_regs.sv
source/read_request_gen.sv
source/line_unpacker.sv
source/sram_cmd_issuer.sv
source/data_feeder_top.sv
verification/tb_data_feeder.sv

// ==== verification/tb_data_feeder.sv ====
`include "feeder_defines.svh"

module tb_data_feeder;

    import feeder_cmd_pkg::*;

    localparam int BUS_TIMEOUT = 16;
    localparam int RUN_TIMEOUT = 4000;
    localparam int POLL_LIMIT  = 400;

    logic                   clk_i;
    logic                   rst_i;
    logic                   bus_strobe_i;
    logic [31:0]            bus_addr_i;
    logic                   bus_rw_i;
    logic [`XLEN-1:0]       bus_wdata_i;
    logic                   bus_ready_o;
    logic [`XLEN-1:0]       bus_rdata_o;
    logic                   fifo_addr_full_i;
    logic                   dram_addr_valid_o;
    logic [31:0]            dram_addr_o;
    logic                   fifo_data_empty_i;
    logic [`HALF_BITS-1:0]  dram_rdata_h_i;
    logic [`HALF_BITS-1:0]  dram_rdata_l_i;
    logic                   fifo_data_rd_en_o;
    logic                   cmd_valid_o;
    opcode_e                cmd_o;
    logic [`DATA_WIDTH-1:0] cmd_data_o;
    logic [`ADDR_BITS-1:0]  cmd_index_o;

    // dram model and command monitor state
    logic [31:0]            lfsr_q;
    logic                   rand_full;
    logic [31:0]            req_q[$];
    logic [`LINE_BITS-1:0]  line_q[$];
    logic [`CMD_WIDTH-1:0]  op_q[$];
    logic [`DATA_WIDTH-1:0] data_q[$];
    logic [`ADDR_BITS-1:0]  idx_q[$];
    int                     pops;
    int                     checks;
    int                     errors;
    int                     test_base;

    data_feeder_top u_dut (.*);

    always #50 clk_i = ~clk_i;

    // ######################################################################
    // helpers
    // ######################################################################

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // element at byte b is b/2 scrambled
    function automatic logic [15:0] elem_at(input logic [31:0] b);
        return b[16:1] ^ 16'hA5C3;
    endfunction

    // word k from the top of each half holds element 2k low, 2k+1 high
    function automatic logic [`LINE_BITS-1:0] line_for(input logic [31:0] addr);
        logic [`LINE_BITS-1:0] line;
        logic [31:0]           base;
        int                    j;
        int                    pos;
        base = {addr[31:6], 6'b0};
        for (int e = 0; e < 32; e++) begin
            j   = e % 16;
            pos = (e / 16) * 256 + 224 - 32 * (j / 2) + 16 * (j % 2);
            line[pos +: 16] = elem_at(base + 2 * e);
        end
        return line;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t: %s never happened", $time, what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic end_test(input string name);
        $display("%s done, %0d mismatches", name, errors - test_base);
    endtask

    task automatic clear_monitors();
        req_q.delete();
        op_q.delete();
        data_q.delete();
        idx_q.delete();
        pops = 0;
    endtask

    // ready must come exactly one cycle after the strobe
    task automatic bus_access(input logic rw, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(negedge clk_i);
        check_eq(bus_ready_o, 0, "ready high without a strobe");
        bus_strobe_i = 1'b1;
        bus_rw_i     = rw;
        bus_addr_i   = addr;
        bus_wdata_i  = wdata;
        @(negedge clk_i);
        bus_strobe_i = 1'b0;
        bus_rw_i     = 1'b0;
        waited       = 1;
        while (!bus_ready_o && waited < BUS_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!bus_ready_o) abort_on_timeout("bus ready");
        check_eq(waited, 1, "bus ready latency");
        rdata = bus_rdata_o;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(1'b1, addr, wdata, unused);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        bus_access(1'b0, addr, '0, rdata);
    endtask

    task automatic start_feed(input logic [31:0] addr, input logic [31:0] len);
        bus_write(`REG_READ_ADDR, addr);
        bus_write(`REG_READ_LEN, len);
        bus_write(`REG_START, 32'd1);
    endtask

    task automatic wait_cmds(input int n);
        int t;
        t = 0;
        while (data_q.size() < n && t < RUN_TIMEOUT) begin
            @(posedge clk_i);
            t++;
        end
        if (data_q.size() < n) abort_on_timeout("all accelerator commands");
    endtask

    task automatic wait_idle();
        logic [31:0] rd;
        int          tries;
        rd    = 32'd1;
        tries = 0;
        while (rd != 0 && tries < POLL_LIMIT) begin
            bus_read(`REG_BUSY, rd);
            tries++;
        end
        if (rd != 0) abort_on_timeout("busy going low");
    endtask

    // ######################################################################
    // dram model with address fifo, data fifo and command capture
    // ######################################################################
    always @(negedge clk_i) begin
        if (dram_addr_valid_o) begin
            // full still holds the value the dut sampled
            check_eq(fifo_addr_full_i, 0, "request issued after a full cycle");
            req_q.push_back(dram_addr_o);
            line_q.push_back(line_for(dram_addr_o));
        end
        if (fifo_data_rd_en_o) begin
            pops++;
            if (line_q.size() == 0) begin
                errors++;
                $display("data FIFO popped while empty at time %0t", $time);
            end else begin
                void'(line_q.pop_front());
            end
        end
        if (cmd_valid_o) begin
            op_q.push_back(cmd_o);
            data_q.push_back(cmd_data_o);
            idx_q.push_back(cmd_index_o);
        end
        if (rand_full) begin
            lfsr_q           = lfsr_next(lfsr_q);
            fifo_addr_full_i = lfsr_q[0];
        end else begin
            fifo_addr_full_i = 1'b0;
        end
        fifo_data_empty_i = (line_q.size() == 0);
        if (line_q.size() != 0) {dram_rdata_h_i, dram_rdata_l_i} = line_q[0];
    end

    // ######################################################################
    // directed tests
    // ######################################################################
    task automatic test_bus_ready();
        logic [31:0] rd;
        test_base = errors;
        check_eq(bus_ready_o, 0, "ready after reset");
        check_eq(dram_addr_valid_o, 0, "request valid after reset");
        check_eq(fifo_data_rd_en_o, 0, "pop after reset");
        check_eq(cmd_valid_o, 0, "command valid after reset");
        bus_write(`REG_READ_ADDR, 32'h0000_1234);
        bus_read(`REG_BUSY, rd);
        check_eq(rd, 0, "busy after reset");
        bus_read(`REG_READ_ADDR, rd);
        check_eq(rd, 0, "read of a write-only register");
        end_test("bus ready and reset");
    endtask

    task automatic test_request_alignment();
        logic [31:0] exp_q[$];
        logic [31:0] a;
        int          covered;
        test_base = errors;
        clear_monitors();
        a       = 32'h0000_103A;
        covered = 0;
        while (covered < 40) begin
            exp_q.push_back(a);
            covered += (64 - a % 64) / 2;
            a += 64 - a % 64;
        end
        @(posedge clk_i);
        rand_full = 1'b1;
        start_feed(32'h0000_103A, 40);
        wait_idle();
        @(posedge clk_i);
        rand_full = 1'b0;
        check_eq(req_q.size(), exp_q.size(), "request count");
        foreach (exp_q[i]) begin
            if (i < req_q.size()) check_eq(req_q[i], exp_q[i], "request address");
        end
        check_eq(line_q.size(), 0, "lines left in data FIFO");
        end_test("request alignment");
    endtask

    task automatic test_input_layout();
        logic [31:0] idx;
        int          n;
        test_base = errors;
        clear_monitors();
        bus_write(`REG_DATA_TYPE, 32'd0);
        bus_write(`REG_INPUT_LENGTH, 32'd4);
        bus_write(`REG_INPUT_HEIGHT, 32'd3);
        bus_write(`REG_PADDING, 32'd1);
        bus_write(`REG_BOUNDARY_PADDING, 32'd5);
        bus_write(`REG_SRAM_OFFSET, 32'd100);
        start_feed(32'h0000_2010, 12);
        wait_cmds(12);
        wait_idle();
        check_eq(data_q.size(), 12, "input command count");
        idx = 100;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 4; c++) begin
                n = r * 4 + c;
                check_eq(op_q[n], CMD_WRITE_INPUT, "input opcode");
                check_eq(data_q[n], elem_at(32'h0000_2010 + 2 * n), "input data");
                check_eq(idx_q[n], idx, "input sram index");
                // row end skips padding and last row skips the border
                if (c == 3 && r == 2) idx += 5 + 1;
                else if (c == 3) idx += 2 * 1 + 1;
                else idx += 1;
            end
        end
        end_test("input layout");
    endtask

    task automatic test_weight_load();
        test_base = errors;
        clear_monitors();
        bus_write(`REG_DATA_TYPE, 32'd1);
        bus_write(`REG_SRAM_OFFSET, 32'd500);
        // starts eight elements before a line boundary
        start_feed(32'h0000_3030, 20);
        wait_cmds(20);
        wait_idle();
        check_eq(data_q.size(), 20, "weight command count");
        check_eq(pops, 2, "weight line pops");
        for (int i = 0; i < 20; i++) begin
            check_eq(op_q[i], CMD_WRITE_WEIGHT, "weight opcode");
            check_eq(data_q[i], elem_at(32'h0000_3030 + 2 * i), "weight data");
            check_eq(idx_q[i], 500 + i, "weight sram index");
        end
        end_test("weight load");
    endtask

    task automatic test_peek();
        logic [31:0] rd;
        test_base = errors;
        clear_monitors();
        bus_write(`REG_LOAD_MODE, 32'd1);
        start_feed(32'h0000_4056, 1);
        wait_idle();
        bus_read(`REG_PEEK_DATA, rd);
        check_eq(rd, elem_at(32'h0000_4056), "peek data");
        check_eq(pops, 1, "peek pops");
        check_eq(data_q.size(), 0, "commands in peek mode");
        check_eq(line_q.size(), 0, "lines left after peek");
        bus_write(`REG_LOAD_MODE, 32'd0);
        end_test("peek mode");
    endtask

    task automatic test_busy_flag();
        logic [31:0] rd;
        test_base = errors;
        clear_monitors();
        start_feed(32'h0000_5000, 64);
        bus_read(`REG_BUSY, rd);
        check_eq(rd, 1, "busy during transfer");
        wait_cmds(64);
        bus_read(`REG_BUSY, rd);
        check_eq(rd, 0, "busy after last command");
        end_test("busy flag");
    endtask

    initial begin
        clk_i             = 1'b0;
        rst_i             = 1'b1;
        bus_strobe_i      = 1'b0;
        bus_addr_i        = '0;
        bus_rw_i          = 1'b0;
        bus_wdata_i       = '0;
        fifo_addr_full_i  = 1'b0;
        fifo_data_empty_i = 1'b1;
        dram_rdata_h_i    = '0;
        dram_rdata_l_i    = '0;
        lfsr_q            = 32'h55dc1842;
        rand_full         = 1'b0;
        pops              = 0;
        checks            = 0;
        errors            = 0;
        repeat (3) @(negedge clk_i);
        rst_i = 1'b0;

        test_bus_ready();
        test_request_alignment();
        test_input_layout();
        test_weight_load();
        test_peek();
        test_busy_flag();

        $display("%0d checks, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
